// File: hw/cache_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_data_ram
    import cache_pkg::*;
(
    input  wire                       clk,
    input  wire [`LINE_IDX_BITS-1:0]  line,
    input  wire [WORD_BITS-1:0]       word_sel,
    input  wire [7:0]                 word_we,
    input  wire [63:0]                wdata,
    input  wire                       refill_we,
    input  wire [`LINE_BITS-1:0]      refill_data,
    input  wire                       uncached_sel,
    input  wire [63:0]                uncached_rdata,
    output logic [63:0]               rdata,
    output logic [`LINE_BITS-1:0]     line_data
);

    localparam int WORD_W = `LINE_BITS / `WORDS_PER_LINE;

    logic [`LINE_BITS-1:0] mem [`NUM_LINES];
    logic [`LINE_BITS-1:0] rd_line;
    logic [WORD_W-1:0]     rd_word;

    // refill takes the whole line, otherwise strobed bytes of one word
    always_ff @(posedge clk) begin
        if (refill_we) begin
            mem[line] <= refill_data;
        end else begin
            for (int b = 0; b < 8; b++) begin
                if (word_we[b]) begin
                    mem[line][word_sel * WORD_W + b * 8 +: 8] <= wdata[b * 8 +: 8];
                end
            end
        end
    end

    assign rd_line = mem[line];
    assign rd_word = rd_line[word_sel * WORD_W +: WORD_W];

    assign rdata = uncached_sel ? uncached_rdata : rd_word;

    // uncached writes carry the cpu word in slot 0
    assign line_data = uncached_sel ? {rd_line[`LINE_BITS-1:WORD_W], wdata} : rd_line;

endmodule

`default_nettype wire

// File: hw/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// set geometry
`define CACHE_SETS      32
`define SET_IDX_BITS    5
`define CACHE_WAYS_LOG  1

// a line index is the set index with the way appended
`define NUM_LINES       (`CACHE_SETS << `CACHE_WAYS_LOG)
`define LINE_IDX_BITS   (`SET_IDX_BITS + `CACHE_WAYS_LOG)

// line layout
`define LINE_BITS       512
`define WORDS_PER_LINE  8

// address map
`define ADDR_BITS       32
// cached region when this bit is set
`define UNCACHED_BIT    31

`endif

// File: hw/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    localparam int BYTE_BITS   = 3;
    localparam int WORD_BITS   = $clog2(`WORDS_PER_LINE);
    localparam int OFFSET_BITS = WORD_BITS + BYTE_BITS;
    localparam int TAG_BITS    = `ADDR_BITS - `SET_IDX_BITS - OFFSET_BITS;

    // cached view of an address
    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [`SET_IDX_BITS-1:0] index;
        logic [WORD_BITS-1:0]     word;
        logic [BYTE_BITS-1:0]     byte_off;
    } cache_addr_fields_t;

    // raw view used for uncached bus addresses
    typedef union packed {
        cache_addr_fields_t    f;
        logic [`ADDR_BITS-1:0] raw;
    } cache_addr_u;

    typedef struct packed {
        logic        op;
        cache_addr_u addr;
        logic [7:0]  wstrb;
        logic [63:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0] addr;
        logic                  rd_req;
        logic                  wr_req;
    } bus_req_t;

endpackage

`default_nettype wire

// File: hw/cache_tag_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tag_ctrl
    import cache_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       valid,
    input  wire cpu_req_t             req,
    input  wire                       fence,
    input  wire                       rd_ready,
    input  wire [63:0]                rd_data_word0,
    input  wire                       wr_ready,
    output logic                      ready,
    output logic                      ok,
    output logic [63:0]               uncached_rdata,
    output logic                      uncached_sel,
    output bus_req_t                  bus,
    output logic [`LINE_IDX_BITS-1:0] ram_line,
    output logic [7:0]                ram_word_we,
    output logic                      ram_refill_we
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_REFILL = 2'd1;
    localparam logic [1:0] ST_WB     = 2'd2;
    localparam logic [1:0] ST_FENCE  = 2'd3;

    logic [1:0]                state;
    logic [`LINE_IDX_BITS-1:0] fence_cnt;
    logic                      fill_way;
    logic                      unc_done;

    logic [TAG_BITS-1:0]       tag_mem [`NUM_LINES];
    logic [`NUM_LINES-1:0]     line_valid;
    logic [`NUM_LINES-1:0]     line_dirty;
    // most recently used way per set
    logic [`CACHE_SETS-1:0]    mru;

    cache_addr_fields_t        a;
    logic                      uncached;
    logic [`LINE_IDX_BITS-1:0] line0;
    logic [`LINE_IDX_BITS-1:0] line1;
    logic [`LINE_IDX_BITS-1:0] victim_line;
    logic [`LINE_IDX_BITS-1:0] fill_line;
    logic                      hit0;
    logic                      hit1;
    logic                      hit;
    logic                      miss;
    logic                      victim;
    logic                      victim_dirty;
    logic                      fence_dirty;
    logic                      fence_last;

    assign a        = req.addr.f;
    assign uncached = ~req.addr.raw[`UNCACHED_BIT];
    assign line0    = {a.index, 1'b0};
    assign line1    = {a.index, 1'b1};

    assign hit0 = line_valid[line0] && (tag_mem[line0] == a.tag);
    assign hit1 = line_valid[line1] && (tag_mem[line1] == a.tag);
    assign hit  = valid && !uncached && (state == ST_IDLE) && (hit0 || hit1);
    assign miss = valid && !uncached && (state == ST_IDLE) && !hit0 && !hit1;

    // invalid way, then the single clean way, then least recent
    always_comb begin
        if (!line_valid[line0]) begin
            victim = 1'b0;
        end else if (!line_valid[line1]) begin
            victim = 1'b1;
        end else if (line_dirty[line0] != line_dirty[line1]) begin
            victim = line_dirty[line0];
        end else begin
            victim = ~mru[a.index];
        end
    end

    assign victim_line  = {a.index, victim};
    assign victim_dirty = line_valid[victim_line] && line_dirty[victim_line];
    assign fill_line    = {a.index, fill_way};
    assign fence_dirty  = line_valid[fence_cnt] && line_dirty[fence_cnt];
    assign fence_last   = &fence_cnt;

    assign ready         = (state == ST_IDLE);
    assign ok            = hit || (valid && uncached && unc_done);
    assign uncached_sel  = valid && uncached;
    assign ram_word_we   = (hit && req.op) ? req.wstrb : 8'h00;
    assign ram_refill_we = (state == ST_REFILL) && rd_ready && !uncached;

    always_comb begin
        if (state == ST_FENCE) begin
            ram_line = fence_cnt;
        end else if (state == ST_IDLE) begin
            ram_line = hit ? {a.index, hit1} : victim_line;
        end else begin
            ram_line = fill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            fence_cnt  <= '0;
            unc_done   <= 1'b0;
            bus.rd_req <= 1'b0;
            bus.wr_req <= 1'b0;
        end else begin
            unc_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (fence) begin
                        state     <= ST_FENCE;
                        fence_cnt <= '0;
                    end else if (valid && uncached && !unc_done) begin
                        // single word straight to the bus
                        bus.addr   <= req.addr.raw;
                        bus.rd_req <= !req.op;
                        bus.wr_req <= req.op;
                        state      <= req.op ? ST_WB : ST_REFILL;
                    end else if (miss) begin
                        fill_way <= victim;
                        if (victim_dirty) begin
                            bus.addr   <= {tag_mem[victim_line], a.index, {OFFSET_BITS{1'b0}}};
                            bus.wr_req <= 1'b1;
                            state      <= ST_WB;
                        end else begin
                            bus.addr   <= {a.tag, a.index, {OFFSET_BITS{1'b0}}};
                            bus.rd_req <= 1'b1;
                            state      <= ST_REFILL;
                        end
                    end
                end
                ST_WB: begin
                    if (wr_ready) begin
                        bus.wr_req <= 1'b0;
                        if (uncached) begin
                            state    <= ST_IDLE;
                            unc_done <= 1'b1;
                        end else begin
                            // victim is out, now fetch the new line
                            bus.addr   <= {a.tag, a.index, {OFFSET_BITS{1'b0}}};
                            bus.rd_req <= 1'b1;
                            state      <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    if (rd_ready) begin
                        bus.rd_req <= 1'b0;
                        state      <= ST_IDLE;
                        unc_done   <= uncached;
                    end
                end
                default: begin
                    if (bus.wr_req) begin
                        if (wr_ready) begin
                            bus.wr_req <= 1'b0;
                            fence_cnt  <= fence_cnt + 1'b1;
                            if (fence_last) begin
                                state <= ST_IDLE;
                            end
                        end
                    end else if (fence_dirty) begin
                        bus.addr   <= {tag_mem[fence_cnt], fence_cnt[`LINE_IDX_BITS-1:1],
                                       {OFFSET_BITS{1'b0}}};
                        bus.wr_req <= 1'b1;
                    end else begin
                        // clean or invalid, skip
                        fence_cnt <= fence_cnt + 1'b1;
                        if (fence_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            line_dirty <= '0;
            mru        <= '0;
        end else begin
            if (hit) begin
                mru[a.index] <= hit1;
                if (req.op) begin
                    line_dirty[{a.index, hit1}] <= 1'b1;
                end
            end
            if (ram_refill_we) begin
                line_valid[fill_line] <= 1'b1;
                line_dirty[fill_line] <= 1'b0;
            end
            if ((state == ST_WB) && wr_ready && !uncached) begin
                line_dirty[fill_line] <= 1'b0;
            end
            if ((state == ST_FENCE) && bus.wr_req && wr_ready) begin
                line_dirty[fence_cnt] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_refill_we) begin
            tag_mem[fill_line] <= a.tag;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_REFILL) && rd_ready) begin
            uncached_rdata <= rd_data_word0;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_top
    import cache_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    valid,
    input  wire cpu_req_t          req,
    input  wire                    fence,
    input  wire                    rd_ready,
    input  wire [`LINE_BITS-1:0]   rd_data,
    input  wire                    wr_ready,
    output logic                   ready,
    output logic                   ok,
    output logic [63:0]            rdata,
    output bus_req_t               bus,
    output logic [`LINE_BITS-1:0]  wr_data
);

    logic [`LINE_IDX_BITS-1:0] ram_line;
    logic [7:0]                ram_word_we;
    logic                      ram_refill_we;
    logic [63:0]               uncached_rdata;
    logic                      uncached_sel;

    cache_tag_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .req            (req),
        .fence          (fence),
        .rd_ready       (rd_ready),
        .rd_data_word0  (rd_data[63:0]),
        .wr_ready       (wr_ready),
        .ready          (ready),
        .ok             (ok),
        .uncached_rdata (uncached_rdata),
        .uncached_sel   (uncached_sel),
        .bus            (bus),
        .ram_line       (ram_line),
        .ram_word_we    (ram_word_we),
        .ram_refill_we  (ram_refill_we)
    );

    cache_data_ram data_i (
        .clk            (clk),
        .line           (ram_line),
        .word_sel       (req.addr.f.word),
        .word_we        (ram_word_we),
        .wdata          (req.wdata),
        .refill_we      (ram_refill_we),
        .refill_data    (rd_data),
        .uncached_sel   (uncached_sel),
        .uncached_rdata (uncached_rdata),
        .rdata          (rdata),
        .line_data      (wr_data)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cache_tb -f sources.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// File: sources.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_tag_ctrl.sv
hw/cache_data_ram.sv
hw/cache_top.sv
tb/line_mem_model.sv
tb/cache_tb.sv

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int NUM_STEPS      = 16;
    localparam int MEM_BYTES      = 16384;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic        is_fence;
        logic        op;
        logic [31:0] addr;
        logic [7:0]  wstrb;
        logic [63:0] wdata;
        logic        exp_hit;
        logic [1:0]  exp_writes;
        logic [31:0] wb_addr;
    } step_t;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    cpu_req_t              req;
    logic                  fence;
    logic                  rd_ready;
    logic [`LINE_BITS-1:0] rd_data;
    logic                  wr_ready;
    logic                  ready;
    logic                  ok;
    logic [63:0]           rdata;
    bus_req_t              bus;
    logic [`LINE_BITS-1:0] wr_data;

    step_t      steps [NUM_STEPS];
    logic [7:0] shadow [MEM_BYTES];
    int         checks;
    int         errors;
    int         timeouts;

    cache_top cache_top_i (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .req      (req),
        .fence    (fence),
        .rd_ready (rd_ready),
        .rd_data  (rd_data),
        .wr_ready (wr_ready),
        .ready    (ready),
        .ok       (ok),
        .rdata    (rdata),
        .bus      (bus),
        .wr_data  (wr_data)
    );

    line_mem_model mem_model_i (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .wr_data  (wr_data),
        .rd_ready (rd_ready),
        .wr_ready (wr_ready),
        .rd_data  (rd_data)
    );

    always #10 clk = ~clk;

    task automatic load_steps();
        // fence, op, addr, wstrb, wdata, same-cycle ok, bus writes, writeback address
        steps[0]  = '{1'b0, 1'b0, 32'h8000_00C0, 8'h00, 64'h0, 1'b0, 2'd0, 32'h0};
        steps[1]  = '{1'b0, 1'b0, 32'h8000_00C8, 8'h00, 64'h0, 1'b1, 2'd0, 32'h0};
        steps[2]  = '{1'b0, 1'b1, 32'h8000_00C8, 8'h0F, 64'h1122_3344_5566_7788,
                      1'b1, 2'd0, 32'h0};
        steps[3]  = '{1'b0, 1'b0, 32'h8000_00C8, 8'h00, 64'h0, 1'b1, 2'd0, 32'h0};
        // second and third tag at set 3, the third evicts the dirty first line
        steps[4]  = '{1'b0, 1'b1, 32'h8000_08C0, 8'hFF, 64'hA5A5_0000_FFFF_1234,
                      1'b0, 2'd0, 32'h0};
        steps[5]  = '{1'b0, 1'b0, 32'h8000_10C0, 8'h00, 64'h0, 1'b0, 2'd1, 32'h8000_00C0};
        steps[6]  = '{1'b0, 1'b0, 32'h8000_00C8, 8'h00, 64'h0, 1'b0, 2'd0, 32'h0};
        steps[7]  = '{1'b0, 1'b0, 32'h8000_08C0, 8'h00, 64'h0, 1'b1, 2'd0, 32'h0};
        steps[8]  = '{1'b0, 1'b0, 32'h8000_10C0, 8'h00, 64'h0, 1'b0, 2'd0, 32'h0};
        // uncached word
        steps[9]  = '{1'b0, 1'b1, 32'h0000_3F00, 8'hFF, 64'hDEAD_BEEF_0BAD_F00D,
                      1'b0, 2'd1, 32'h0000_3F00};
        steps[10] = '{1'b0, 1'b0, 32'h0000_3F00, 8'h00, 64'h0, 1'b0, 2'd0, 32'h0};
        steps[11] = '{1'b0, 1'b0, 32'h8000_08D8, 8'h00, 64'h0, 1'b1, 2'd0, 32'h0};
        steps[12] = '{1'b0, 1'b1, 32'h8000_0148, 8'hF0, 64'h0102_0304_0506_0708,
                      1'b0, 2'd0, 32'h0};
        // two dirty lines left for the first fence, none for the second
        steps[13] = '{1'b1, 1'b0, 32'h0, 8'h00, 64'h0, 1'b0, 2'd2, 32'h0};
        steps[14] = '{1'b1, 1'b0, 32'h0, 8'h00, 64'h0, 1'b0, 2'd0, 32'h0};
        steps[15] = '{1'b0, 1'b0, 32'h8000_0148, 8'h00, 64'h0, 1'b1, 2'd0, 32'h0};
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [63:0] shadow_word(input logic [31:0] addr);
        logic [63:0] w;
        int          base;
        base = {addr[13:3], 3'b000};
        for (int b = 0; b < 8; b++) begin
            w[b * 8 +: 8] = shadow[base + b];
        end
        return w;
    endfunction

    task automatic update_shadow(input step_t s);
        int base;
        base = {s.addr[13:3], 3'b000};
        for (int b = 0; b < 8; b++) begin
            // uncached writes move the whole word
            if (s.wstrb[b] || !s.addr[`UNCACHED_BIT]) begin
                shadow[base + b] = s.wdata[b * 8 +: 8];
            end
        end
    endtask

    task automatic compare_memory();
        for (int w = 0; w < MEM_BYTES / 8; w++) begin
            check_value($sformatf("mem word %0h", w * 8),
                        mem_model_i.mem[w / 8][(w % 8) * 64 +: 64], shadow_word(32'(w * 8)));
        end
    endtask

    task automatic run_access(input step_t s, input int idx);
        int          wr_before;
        int          cycles;
        logic [63:0] expected;
        wr_before = mem_model_i.wr_count;
        expected  = shadow_word(s.addr);
        @(posedge clk);
        #2;
        req.op       = s.op;
        req.addr.raw = s.addr;
        req.wstrb    = s.wstrb;
        req.wdata    = s.wdata;
        valid        = 1'b1;
        cycles       = 0;
        @(negedge clk);
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!ok) begin
            timeouts++;
            $display("step %0d: no ok from the cache within %0d cycles", idx, TIMEOUT_CYCLES);
        end else begin
            check_value("ok_same_cycle", cycles == 0, s.exp_hit);
            if (!s.op) begin
                check_value("rdata", rdata, expected);
            end
        end
        @(posedge clk);
        #2;
        valid = 1'b0;
        if (s.op) begin
            update_shadow(s);
        end
        check_value("bus_writes", mem_model_i.wr_count - wr_before, s.exp_writes);
        if (s.exp_writes == 2'd1) begin
            check_value("bus.addr", mem_model_i.last_wr_addr, s.wb_addr);
        end
    endtask

    task automatic run_fence(input step_t s, input int idx);
        int wr_before;
        int cycles;
        wr_before = mem_model_i.wr_count;
        @(posedge clk);
        #2;
        fence = 1'b1;
        @(posedge clk);
        #2;
        fence  = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            timeouts++;
            $display("step %0d: fence walk did not finish within %0d cycles",
                     idx, TIMEOUT_CYCLES);
        end
        check_value("bus_writes", mem_model_i.wr_count - wr_before, s.exp_writes);
        compare_memory();
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        valid    = 1'b0;
        req      = '0;
        fence    = 1'b0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        load_steps();
        // memory model preloads at time zero
        #1;
        for (int a = 0; a < MEM_BYTES; a++) begin
            shadow[a] = mem_model_i.mem[a / 64][(a % 64) * 8 +: 8];
        end
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        check_value("ready", ready, 1'b1);
        check_value("bus.rd_req", bus.rd_req, 1'b0);
        check_value("bus.wr_req", bus.wr_req, 1'b0);
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].is_fence) begin
                run_fence(steps[i], i);
            end else begin
                run_access(steps[i], i);
            end
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/line_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module line_mem_model
    import cache_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire bus_req_t          bus,
    input  wire [`LINE_BITS-1:0]   wr_data,
    output logic                   rd_ready,
    output logic                   wr_ready,
    output logic [`LINE_BITS-1:0]  rd_data
);

    localparam int NUM_MEM_LINES = 256;

    logic [`LINE_BITS-1:0] mem [NUM_MEM_LINES];
    integer                seed = 32301;
    int                    wr_count;
    logic [`ADDR_BITS-1:0] last_wr_addr;
    logic [7:0]            line_idx;
    logic [2:0]            word_idx;
    logic                  word_access;

    // byte value mixes every bit of its 14-bit address
    initial begin
        logic [13:0] a;
        for (int i = 0; i < NUM_MEM_LINES * 64; i++) begin
            a = 14'(i);
            mem[i / 64][(i % 64) * 8 +: 8] = a[7:0] ^ {a[13:8], 2'b01};
        end
        // bus side idle before the first edge
        rd_ready = 1'b0;
        wr_ready = 1'b0;
        rd_data  = '0;
    end

    assign line_idx    = bus.addr[13:6];
    assign word_idx    = bus.addr[5:3];
    // uncached traffic moves one word in slot 0
    assign word_access = !bus.addr[`UNCACHED_BIT];

    always @(posedge clk) begin
        rd_ready <= 1'b0;
        wr_ready <= 1'b0;
        if (rst) begin
            wr_count <= 0;
            rd_data  <= '0;
        end else if ((bus.rd_req || bus.wr_req) && !rd_ready && !wr_ready
                     && (($random(seed) & 3) == 0)) begin
            if (bus.wr_req) begin
                wr_ready     <= 1'b1;
                wr_count     <= wr_count + 1;
                last_wr_addr <= bus.addr;
                if (word_access) begin
                    mem[line_idx][word_idx * 64 +: 64] <= wr_data[63:0];
                end else begin
                    mem[line_idx] <= wr_data;
                end
            end else begin
                rd_ready <= 1'b1;
                if (word_access) begin
                    rd_data <= {448'b0, mem[line_idx][word_idx * 64 +: 64]};
                end else begin
                    rd_data <= mem[line_idx];
                end
            end
        end
    end

endmodule

`default_nettype wire
